// File: src/ifetch_config.svh
`ifndef IFETCH_CONFIG_SVH
`define IFETCH_CONFIG_SVH

// Address and instruction word widths
`define IFETCH_ADDR_WIDTH 32
`define IFETCH_DATA_WIDTH 32

// Cache geometry, one word per line
`define IFETCH_OFFSET_WIDTH 2
`define IFETCH_INDEX_WIDTH 3

// First fetch address, start of flash
`define IFETCH_RESET_PC 32'h3000_0000

// Event counter width
`define IFETCH_COUNT_WIDTH 32

`endif

// File: src/ifetch_pkg.sv
`include "ifetch_config.svh"

package ifetch_pkg;

    typedef logic [`IFETCH_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`IFETCH_DATA_WIDTH-1:0] data_t;
    typedef logic [`IFETCH_COUNT_WIDTH-1:0] count_t;
    typedef logic [1:0] region_t;

    // Memory region codes
    localparam region_t REGION_NONE = 2'd0;
    localparam region_t REGION_FLASH = 2'd1;
    localparam region_t REGION_SRAM = 2'd2;
    localparam region_t REGION_SDRAM = 2'd3;

    // Cache lookup sequence
    typedef enum logic [1:0] {IDLE, LOOKUP, MISS} cache_state_t;

    // One outstanding fetch at a time
    typedef enum logic {ISSUE, WAIT} fetch_state_t;

endpackage

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`include "ifetch_config.svh"

module fetch_unit import ifetch_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  fetch_stall,
    input  logic  redirect,
    input  addr_t redirect_pc,
    input  logic  req_ready,
    input  logic  resp_valid,
    input  data_t resp_data,
    output logic  req_valid,
    output addr_t req_addr,
    output logic  instr_valid,
    output data_t instr,
    output addr_t instr_pc
);

    fetch_state_t state;
    addr_t        pc;
    addr_t        redirect_target;
    logic         redirect_pending;
    logic         accept;

    assign req_valid = (state == ISSUE) && !fetch_stall;
    assign req_addr  = pc;
    assign accept    = req_valid && req_ready;

    // ------------------------------------------------------------
    // Request sequencing and PC update
    // ------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state            <= ISSUE;
            pc               <= `IFETCH_RESET_PC;
            redirect_pending <= 1'b0;
            instr_valid      <= 1'b0;
        end else begin
            instr_valid <= resp_valid;
            case (state)
                ISSUE:   if (accept) state <= WAIT;
                WAIT:    if (resp_valid) state <= ISSUE;
                default: state <= ISSUE;
            endcase
            if (resp_valid) begin
                // A redirect in the response cycle wins over an older one
                if (redirect)
                    pc <= redirect_pc;
                else if (redirect_pending)
                    pc <= redirect_target;
                else
                    pc <= pc + 4;
                redirect_pending <= 1'b0;
            end else if (redirect) begin
                // Nothing in flight, so steer the next request directly
                if (state == ISSUE && !accept)
                    pc <= redirect_pc;
                else
                    redirect_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (redirect)
            redirect_target <= redirect_pc;
        if (resp_valid) begin
            instr    <= resp_data;
            instr_pc <= pc;
        end
    end

endmodule

// File: src/icache.sv
`timescale 1ns/1ps
`include "ifetch_config.svh"

module icache import ifetch_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  invalidate,
    input  logic  req_valid,
    input  addr_t req_addr,
    input  logic  mem_arready,
    input  logic  mem_rvalid,
    input  data_t mem_rdata,
    output logic  req_ready,
    output logic  resp_valid,
    output data_t resp_data,
    output logic  mem_arvalid,
    output addr_t mem_araddr,
    output logic  cache_hit,
    output logic  cache_fill,
    output addr_t access_addr
);

    localparam int TAG_WIDTH = `IFETCH_ADDR_WIDTH - `IFETCH_INDEX_WIDTH - `IFETCH_OFFSET_WIDTH;
    localparam int LINES = 1 << `IFETCH_INDEX_WIDTH;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    // Line storage
    data_t      data_mem [LINES];
    tag_t       tag_mem [LINES];
    logic [LINES-1:0] valid_bits;

    cache_state_t state;
    addr_t        addr_q;
    logic [`IFETCH_INDEX_WIDTH-1:0] index;
    tag_t         tag;
    logic         hit;
    logic         fill;

    assign index = addr_q[`IFETCH_OFFSET_WIDTH +: `IFETCH_INDEX_WIDTH];
    assign tag   = addr_q[`IFETCH_ADDR_WIDTH-1 -: TAG_WIDTH];

    assign hit  = (state == LOOKUP) && valid_bits[index] && (tag_mem[index] == tag);
    assign fill = (state == MISS) && mem_rvalid;

    // ------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------
    assign req_ready  = (state == IDLE);
    assign resp_valid = hit || fill;
    // Miss data is forwarded straight from memory
    assign resp_data  = (state == MISS) ? mem_rdata : data_mem[index];

    assign mem_araddr  = addr_q;
    assign cache_hit   = hit;
    assign cache_fill  = fill;
    assign access_addr = addr_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (req_valid && req_ready) state <= LOOKUP;
                LOOKUP:  state <= hit ? IDLE : MISS;
                MISS:    if (mem_rvalid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid && req_ready)
            addr_q <= req_addr;
    end

    // ------------------------------------------------------------
    // Miss read toward memory
    // ------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            mem_arvalid <= 1'b0;
        else if (state == LOOKUP && !hit)
            mem_arvalid <= 1'b1;
        else if (mem_arvalid && mem_arready)
            mem_arvalid <= 1'b0;
    end

    // Fill after invalidate so the new line survives
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else begin
            if (invalidate)
                valid_bits <= '0;
            if (fill)
                valid_bits[index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            data_mem[index] <= mem_rdata;
            tag_mem[index]  <= tag;
        end
    end

endmodule

// File: src/region_counter.sv
`timescale 1ns/1ps
`include "ifetch_config.svh"

module region_counter import ifetch_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   cache_hit,
    input  logic   cache_fill,
    input  addr_t  access_addr,
    output count_t flash_hit,
    output count_t flash_miss,
    output count_t sram_hit,
    output count_t sram_miss,
    output count_t sdram_hit,
    output count_t sdram_miss
);

    region_t region;

    // Region decode on the upper address bits
    always_comb begin
        if (access_addr[`IFETCH_ADDR_WIDTH-1 -: 4] == 4'h3)
            region = REGION_FLASH;
        else if (access_addr[`IFETCH_ADDR_WIDTH-1 -: 8] == 8'h0f)
            region = REGION_SRAM;
        else if (access_addr[`IFETCH_ADDR_WIDTH-1 -: 3] == 3'b101)
            region = REGION_SDRAM;  // top nibble a or b
        else
            region = REGION_NONE;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flash_hit  <= '0;
            flash_miss <= '0;
            sram_hit   <= '0;
            sram_miss  <= '0;
            sdram_hit  <= '0;
            sdram_miss <= '0;
        end else begin
            case (region)
                REGION_FLASH: begin
                    if (cache_hit) flash_hit <= flash_hit + 1'b1;
                    if (cache_fill) flash_miss <= flash_miss + 1'b1;
                end
                REGION_SRAM: begin
                    if (cache_hit) sram_hit <= sram_hit + 1'b1;
                    if (cache_fill) sram_miss <= sram_miss + 1'b1;
                end
                REGION_SDRAM: begin
                    if (cache_hit) sdram_hit <= sdram_hit + 1'b1;
                    if (cache_fill) sdram_miss <= sdram_miss + 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: src/ifetch_top.sv
`timescale 1ns/1ps

module ifetch_top import ifetch_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   fetch_stall,
    input  logic   redirect,
    input  addr_t  redirect_pc,
    input  logic   invalidate,
    input  logic   mem_arready,
    input  logic   mem_rvalid,
    input  data_t  mem_rdata,
    output logic   instr_valid,
    output data_t  instr,
    output addr_t  instr_pc,
    output logic   mem_arvalid,
    output addr_t  mem_araddr,
    output count_t flash_hit,
    output count_t flash_miss,
    output count_t sram_hit,
    output count_t sram_miss,
    output count_t sdram_hit,
    output count_t sdram_miss
);

    // Fetch unit to cache
    logic  req_valid;
    logic  req_ready;
    addr_t req_addr;
    logic  resp_valid;
    data_t resp_data;

    // Cache events for the counters
    logic  cache_hit;
    logic  cache_fill;
    addr_t access_addr;

    fetch_unit u_fetch_unit (
        .clock       (clock),
        .reset       (reset),
        .fetch_stall (fetch_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

    icache u_icache (
        .clock       (clock),
        .reset       (reset),
        .invalidate  (invalidate),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .mem_arready (mem_arready),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .mem_arvalid (mem_arvalid),
        .mem_araddr  (mem_araddr),
        .cache_hit   (cache_hit),
        .cache_fill  (cache_fill),
        .access_addr (access_addr)
    );

    region_counter u_region_counter (
        .clock       (clock),
        .reset       (reset),
        .cache_hit   (cache_hit),
        .cache_fill  (cache_fill),
        .access_addr (access_addr),
        .flash_hit   (flash_hit),
        .flash_miss  (flash_miss),
        .sram_hit    (sram_hit),
        .sram_miss   (sram_miss),
        .sdram_hit   (sdram_hit),
        .sdram_miss  (sdram_miss)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Reset held over the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;
    end

endmodule

// File: sim/mem_model.sv
`timescale 1ns/1ps

module mem_model import ifetch_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  arvalid,
    input  addr_t araddr,
    output logic  arready,
    output logic  rvalid,
    output data_t rdata
);

    localparam data_t DATA_KEY = 32'h1357_9bdf;

    logic [31:0] rand_state = 32'h56851407;
    addr_t       addr;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #2;
        end
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        forever begin
            @(posedge clock);
            #2;
            if (!reset && arvalid) begin
                addr       = araddr;
                rand_state = next_random(rand_state);
                wait_cycles(rand_state % 6);
                arready = 1'b1;
                // Address handshake at this edge
                @(posedge clock);
                #2;
                arready    = 1'b0;
                rand_state = next_random(rand_state);
                wait_cycles(rand_state % 6);
                rvalid = 1'b1;
                rdata  = addr ^ DATA_KEY;
                @(posedge clock);
                #2;
                rvalid = 1'b0;
            end
        end
    end

endmodule

// File: sim/tb_ifetch_top.sv
`timescale 1ns/1ps
`include "ifetch_config.svh"

module tb_ifetch_top import ifetch_pkg::*; ();

    localparam data_t DATA_KEY = 32'h1357_9bdf;
    localparam int    TIMEOUT  = 2000;
    localparam addr_t RESET_PC = `IFETCH_RESET_PC;

    logic   clock;
    logic   reset;
    logic   fetch_stall;
    logic   redirect;
    addr_t  redirect_pc;
    logic   invalidate;
    logic   mem_arready;
    logic   mem_rvalid;
    data_t  mem_rdata;
    logic   instr_valid;
    data_t  instr;
    addr_t  instr_pc;
    logic   mem_arvalid;
    addr_t  mem_araddr;
    count_t flash_hit;
    count_t flash_miss;
    count_t sram_hit;
    count_t sram_miss;
    count_t sdram_hit;
    count_t sdram_miss;

    // Reference copy of the cache tags and the expected counters
    addr_t model_line [1 << `IFETCH_INDEX_WIDTH];
    logic [(1 << `IFETCH_INDEX_WIDTH)-1:0] model_valid;
    int exp_hit [4] = '{0, 0, 0, 0};
    int exp_miss [4] = '{0, 0, 0, 0};

    int          error_count  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          mem_reads    = 0;
    logic [31:0] rand_state;

    tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

    ifetch_top u_ifetch_top (
        .clock(clock), .reset(reset), .fetch_stall(fetch_stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .invalidate(invalidate), .mem_arready(mem_arready),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata), .instr_valid(instr_valid),
        .instr(instr), .instr_pc(instr_pc), .mem_arvalid(mem_arvalid),
        .mem_araddr(mem_araddr), .flash_hit(flash_hit), .flash_miss(flash_miss),
        .sram_hit(sram_hit), .sram_miss(sram_miss), .sdram_hit(sdram_hit),
        .sdram_miss(sdram_miss)
    );

    mem_model u_mem (
        .clock(clock), .reset(reset), .arvalid(mem_arvalid), .araddr(mem_araddr),
        .arready(mem_arready), .rvalid(mem_rvalid), .rdata(mem_rdata)
    );

    // ------------------------------------------------------------
    // Protocol and data checks
    // ------------------------------------------------------------
    assert property (@(posedge clock) disable iff (reset)
        instr_valid |-> instr == (instr_pc ^ DATA_KEY))
    else begin
        error_count++;
        $display("Fail at %0t: instr %h at pc %h", $time, $sampled(instr), $sampled(instr_pc));
    end

    assert property (@(posedge clock) disable iff (reset)
        mem_arvalid && !mem_arready |=> mem_arvalid)
    else begin
        error_count++;
        $display("Fail at %0t: mem_arvalid dropped before mem_arready", $time);
    end

    always @(posedge clock)
        if (!reset && mem_arvalid && mem_arready)
            mem_reads <= mem_reads + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int region_of(input addr_t a);
        if (a[31:28] == 4'h3)
            return REGION_FLASH;
        if (a[31:24] == 8'h0f)
            return REGION_SRAM;
        if (a[31:28] == 4'ha || a[31:28] == 4'hb)
            return REGION_SDRAM;
        return REGION_NONE;
    endfunction

    function automatic addr_t pick_base(input logic [1:0] sel);
        case (sel)
            2'd0:    return 32'h3000_0000;
            2'd1:    return 32'h0f00_0000;
            2'd2:    return 32'ha000_0000;
            default: return 32'h8000_0000;
        endcase
    endfunction

    function automatic int counter_total();
        return flash_hit + flash_miss + sram_hit + sram_miss + sdram_hit + sdram_miss;
    endfunction

    // One completed fetch through the reference cache
    task automatic model_access(input addr_t pc);
        int    idx;
        addr_t line;
        idx  = pc[`IFETCH_OFFSET_WIDTH +: `IFETCH_INDEX_WIDTH];
        line = pc >> (`IFETCH_OFFSET_WIDTH + `IFETCH_INDEX_WIDTH);
        if (model_valid[idx] && model_line[idx] == line) begin
            exp_hit[region_of(pc)]++;
        end else begin
            exp_miss[region_of(pc)]++;
            model_valid[idx] = 1'b1;
            model_line[idx]  = line;
        end
    endtask

    task automatic check_count(input string name, input count_t actual, input int expected);
        assert (actual == expected) else begin
            error_count++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_counters();
        check_count("flash_hit", flash_hit, exp_hit[REGION_FLASH]);
        check_count("flash_miss", flash_miss, exp_miss[REGION_FLASH]);
        check_count("sram_hit", sram_hit, exp_hit[REGION_SRAM]);
        check_count("sram_miss", sram_miss, exp_miss[REGION_SRAM]);
        check_count("sdram_hit", sdram_hit, exp_hit[REGION_SDRAM]);
        check_count("sdram_miss", sdram_miss, exp_miss[REGION_SDRAM]);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset && cycles < TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (reset) begin
            error_count++;
            $display("Timeout: reset was never released");
        end
    endtask

    // Steer an idle, stalled fetch unit to pc and let it run
    task automatic start_at(input addr_t pc);
        @(posedge clock);
        #2;
        redirect    = 1'b1;
        redirect_pc = pc;
        @(posedge clock);
        #2;
        redirect    = 1'b0;
        fetch_stall = 1'b0;
    endtask

    task automatic pulse_invalidate();
        @(posedge clock);
        #2;
        invalidate = 1'b1;
        @(posedge clock);
        #2;
        invalidate  = 1'b0;
        model_valid = '0;
    endtask

    // ------------------------------------------------------------
    // Collect n instructions, then stall so nothing is in flight.
    // With shake set, stall and redirect are randomized each cycle.
    // A redirect steers one of the next two requests, so a pc may
    // match any target driven since the previous instruction
    // ------------------------------------------------------------
    task automatic collect(input addr_t first_pc, input int n, input bit shake);
        addr_t expected;
        addr_t target;
        addr_t recent [$];
        addr_t older [$];
        bit    steered;
        int    got;
        int    idle;
        expected = first_pc;
        got      = 0;
        idle     = 0;
        while (got < n && idle < TIMEOUT) begin
            @(posedge clock);
            #2;
            idle++;
            if (instr_valid) begin
                steered = 1'b0;
                foreach (older[i])
                    if (older[i] == instr_pc)
                        steered = 1'b1;
                foreach (recent[i])
                    if (recent[i] == instr_pc)
                        steered = 1'b1;
                assert (instr_pc == expected || steered)
                else begin
                    error_count++;
                    $display("Fail at %0t: pc %h, expected %h", $time, instr_pc, expected);
                end
                model_access(instr_pc);
                expected = instr_pc + 4;
                older    = recent;
                recent.delete();
                got++;
                idle = 0;
            end
            if (shake && got < n) begin
                rand_state  = xorshift(rand_state);
                fetch_stall = (rand_state[1:0] == 2'd0);
                redirect    = (rand_state[6:3] == 4'd0);
                if (redirect) begin
                    target      = pick_base(rand_state[9:8]) + {rand_state[14:10], 2'b00};
                    redirect_pc = target;
                    recent.push_back(target);
                end
            end
        end
        fetch_stall = 1'b1;
        redirect    = 1'b0;
        if (got < n) begin
            error_count++;
            $display("Timeout: only %0d of %0d instructions arrived", got, n);
        end
    endtask

    task automatic fetch_from(input addr_t pc, input int n);
        start_at(pc);
        collect(pc, n, 1'b0);
    endtask

    task automatic report_test(input string name, input int mark);
        if (error_count == mark) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", name, error_count - mark);
        end
    endtask

    initial begin
        int mark;
        int reads;
        int total;
        fetch_stall = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        invalidate  = 1'b0;
        model_valid = '0;
        rand_state  = 32'h56851407;
        wait_reset_release();

        mark = error_count;
        collect(RESET_PC, 8, 1'b0);
        check_count("flash_miss", flash_miss, 8);
        check_count("flash_hit", flash_hit, 0);
        check_counters();
        report_test("1 sequential fetch from reset", mark);

        mark  = error_count;
        reads = mem_reads;
        fetch_from(RESET_PC, 8);
        check_count("memory reads", mem_reads - reads, 0);
        check_count("flash_hit", flash_hit, 8);
        check_counters();
        report_test("2 refetch from cache", mark);

        // Both SRAM addresses land on index 0
        mark = error_count;
        for (int i = 0; i < 8; i++)
            fetch_from(i[0] ? 32'h0f00_0020 : 32'h0f00_0000, 1);
        check_count("sram_miss", sram_miss, 8);
        check_count("sram_hit", sram_hit, 0);
        fetch_from(RESET_PC, 8);
        check_count("flash_miss", flash_miss, 9);
        check_counters();
        report_test("3 conflict eviction", mark);

        mark = error_count;
        pulse_invalidate();
        reads = mem_reads;
        fetch_from(RESET_PC, 8);
        check_count("memory reads", mem_reads - reads, 8);
        check_count("flash_miss", flash_miss, 17);
        check_counters();
        report_test("4 invalidate", mark);

        mark = error_count;
        fetch_from(32'ha000_0000, 2);
        fetch_from(32'hb000_0040, 2);
        fetch_from(32'hb000_0040, 2);
        check_count("sdram_miss", sdram_miss, 4);
        check_count("sdram_hit", sdram_hit, 2);
        total = counter_total();
        fetch_from(32'h8000_0000, 2);
        check_count("counter total", counter_total(), total);
        check_counters();
        report_test("5 regions", mark);

        mark = error_count;
        start_at(RESET_PC);
        collect(RESET_PC, 300, 1'b1);
        check_counters();
        report_test("6 random stress", mark);

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
src/ifetch_pkg.sv
src/fetch_unit.sv
src/icache.sv
src/region_counter.sv
src/ifetch_top.sv
sim/tb_clock_gen.sv
sim/mem_model.sv
sim/tb_ifetch_top.sv

// File: Bender.yml
package:
  name: ifetch

export_include_dirs:
  - src

sources:
  - src/ifetch_pkg.sv
  - src/fetch_unit.sv
  - src/icache.sv
  - src/region_counter.sv
  - src/ifetch_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/mem_model.sv
      - sim/tb_ifetch_top.sv
